// File: rtl/ai_op_decode.sv
`timescale 1ns/1ns

module ai_op_decode
    import ai_pkg::*;
(
    input  logic [FUNC_W-1:0] func_i,
    input  logic [DATA_W-1:0] opnd1_i,
    input  logic [DATA_W-1:0] opnd2_i,
    output ai_op_t            op_o
);

    ai_op_e op;
    logic   use_opnd;  // Operation carries data into a buffer.

    always_comb begin
        case (func_i)
            OP_LDX_ONE: op = OP_LDX_ONE;
            OP_LDX_TWO: op = OP_LDX_TWO;
            OP_LDW_ONE: op = OP_LDW_ONE;
            OP_LDW_TWO: op = OP_LDW_TWO;
            OP_CLRX:    op = OP_CLRX;
            OP_CLRW:    op = OP_CLRW;
            OP_RUN:     op = OP_RUN;
            default:    op = OP_NOP;  // Codes 8 to 15 as well.
        endcase
    end

    always_comb begin
        case (op)
            OP_LDX_ONE,
            OP_LDX_TWO,
            OP_LDW_ONE,
            OP_LDW_TWO: use_opnd = 1'b1;
            default:    use_opnd = 1'b0;
        endcase
    end

    // Non-load operations present zero operands to the buffers.
    always_comb begin
        op_o.op    = op;
        op_o.opnd1 = use_opnd ? opnd1_i : '0;
        op_o.opnd2 = use_opnd ? opnd2_i : '0;
    end

endmodule

// File: rtl/ai_pkg.sv
package ai_pkg;

    localparam int DATA_W = 32;  // Operand and result width.
    localparam int FUNC_W = 4;   // Raw function code width from the core.

    // Encodings match the raw function codes of the core.
    typedef enum logic [FUNC_W-1:0] {
        OP_NOP     = 4'd0,
        OP_LDX_ONE = 4'd1,
        OP_LDX_TWO = 4'd2,
        OP_LDW_ONE = 4'd3,
        OP_LDW_TWO = 4'd4,
        OP_CLRX    = 4'd5,
        OP_CLRW    = 4'd6,
        OP_RUN     = 4'd7
    } ai_op_e;

    // Decoded micro-operation.
    typedef struct packed {
        ai_op_e            op;
        logic [DATA_W-1:0] opnd1;
        logic [DATA_W-1:0] opnd2;
    } ai_op_t;

    // Multiplier request.
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } mul_req_t;

endpackage

// File: rtl/ai_unit_top.sv
`timescale 1ns/1ns

module ai_unit_top
    import ai_pkg::*;
#(
    parameter int N_REGS  = 8,
    parameter int MUL_LAT = 3
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic [FUNC_W-1:0] func_i,
    input  logic [DATA_W-1:0] opnd1_i,
    input  logic [DATA_W-1:0] opnd2_i,
    output logic [DATA_W-1:0] result_o,
    output logic              ready_o
);

    ai_op_t op;  // Decoded operation.

    ai_op_decode i_decode (
        .func_i  (func_i),
        .opnd1_i (opnd1_i),
        .opnd2_i (opnd2_i),
        .op_o    (op)
    );

    dot_unit #(
        .N_REGS  (N_REGS),
        .MUL_LAT (MUL_LAT)
    ) i_dot (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .op_i     (op),
        .result_o (result_o),
        .ready_o  (ready_o)
    );

endmodule

// File: rtl/dot_unit.sv
`timescale 1ns/1ns

module dot_unit
    import ai_pkg::*;
#(
    parameter int N_REGS  = 8,
    parameter int MUL_LAT = 3
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  ai_op_t            op_i,
    output logic [DATA_W-1:0] result_o,
    output logic              ready_o
);

    localparam int CNT_W = $clog2(N_REGS + 1);
    localparam int IDX_W = (N_REGS > 1) ? $clog2(N_REGS) : 1;

    typedef enum logic {
        IDLE,
        WAIT_PRODUCT
    } state_e;

    // Buffer 0 holds x, buffer 1 holds w.
    logic [DATA_W-1:0]   buf_q [2][N_REGS];
    logic [CNT_W-1:0]    fill_q [2];
    logic [CNT_W-1:0]    fill_d [2];
    logic [1:0]          ld_one;
    logic [1:0]          ld_two;
    logic [1:0]          clr;
    logic [1:0]          wr0;
    logic [1:0]          wr1;
    logic                flush;
    logic [CNT_W-1:0]    min_fill;
    logic [CNT_W-1:0]    req_cnt_q;
    logic [CNT_W-1:0]    req_cnt_d;
    logic [CNT_W-1:0]    res_cnt_q;
    logic [CNT_W-1:0]    res_cnt_d;
    logic [DATA_W-1:0]   acc_q;
    logic [DATA_W-1:0]   acc_d;
    state_e              state_q;
    state_e              state_d;
    mul_req_t            req;
    logic [2*DATA_W-1:0] prod;
    logic                prod_valid;

    assign ld_one = {op_i.op == OP_LDW_ONE, op_i.op == OP_LDX_ONE};
    assign ld_two = {op_i.op == OP_LDW_TWO, op_i.op == OP_LDX_TWO};
    assign clr    = {op_i.op == OP_CLRW, op_i.op == OP_CLRX};
    assign flush  = |clr;

    // Writes past the buffer end are dropped one by one.
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            wr0[b] = (ld_one[b] || ld_two[b]) && (fill_q[b] < N_REGS);
            wr1[b] = ld_two[b] && (fill_q[b] + 1 < N_REGS);
            if (clr[b]) begin
                fill_d[b] = '0;
            end else begin
                fill_d[b] = fill_q[b] + CNT_W'(wr0[b]) + CNT_W'(wr1[b]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int b = 0; b < 2; b++) begin
            if (wr0[b]) buf_q[b][IDX_W'(fill_q[b])] <= op_i.opnd1;
            if (wr1[b]) buf_q[b][IDX_W'(fill_q[b] + 1'b1)] <= op_i.opnd2;
        end
    end

    assign min_fill = (fill_q[0] < fill_q[1]) ? fill_q[0] : fill_q[1];

    // Speculative multiply-accumulate, one request in flight at a time.
    always_comb begin
        state_d   = state_q;
        req_cnt_d = req_cnt_q;
        res_cnt_d = res_cnt_q;
        acc_d     = acc_q;
        req.valid = 1'b0;
        req.a     = buf_q[0][IDX_W'(req_cnt_q)];
        req.b     = buf_q[1][IDX_W'(req_cnt_q)];

        case (state_q)
            IDLE: begin
                if (req_cnt_q < min_fill) begin
                    req.valid = 1'b1;
                    req_cnt_d = req_cnt_q + 1'b1;
                    state_d   = WAIT_PRODUCT;
                end
            end
            WAIT_PRODUCT: begin
                if (prod_valid) begin
                    acc_d     = acc_q + prod[DATA_W-1:0];  // Low half only.
                    res_cnt_d = res_cnt_q + 1'b1;
                    if (req_cnt_q < min_fill) begin
                        req.valid = 1'b1;
                        req_cnt_d = req_cnt_q + 1'b1;
                    end else begin
                        state_d = IDLE;
                    end
                end
            end
            default: state_d = IDLE;
        endcase

        // A clear rewinds all speculative work.
        if (flush) begin
            req.valid = 1'b0;
            req_cnt_d = '0;
            res_cnt_d = '0;
            acc_d     = '0;
            state_d   = IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            fill_q    <= '{default: '0};
            req_cnt_q <= '0;
            res_cnt_q <= '0;
            acc_q     <= '0;
            state_q   <= IDLE;
        end else begin
            fill_q    <= fill_d;
            req_cnt_q <= req_cnt_d;
            res_cnt_q <= res_cnt_d;
            acc_q     <= acc_d;
            state_q   <= state_d;
        end
    end

    mul_pipe #(
        .MUL_LAT (MUL_LAT)
    ) i_mul (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_i        (req),
        .flush_i      (flush),
        .prod_o       (prod),
        .prod_valid_o (prod_valid)
    );

    assign result_o = acc_q;
    assign ready_o  = !((op_i.op == OP_RUN) && (res_cnt_q < min_fill));  // Stall run until done.

endmodule

// File: rtl/mul_pipe.sv
`timescale 1ns/1ns

module mul_pipe
    import ai_pkg::*;
#(
    parameter int MUL_LAT = 3
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  mul_req_t            req_i,
    input  logic                flush_i,
    output logic [2*DATA_W-1:0] prod_o,
    output logic                prod_valid_o
);

    logic [2*DATA_W-1:0] prod_q [MUL_LAT];
    logic [MUL_LAT-1:0]  valid_q;

    // Flush drops every product in flight, including this cycle's request.
    always_ff @(posedge clk_i) begin
        if (!rstn_i || flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= req_i.valid;
            for (int s = 1; s < MUL_LAT; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    // Stages only load when their input is valid.
    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            prod_q[0] <= req_i.a * req_i.b;  // Full unsigned product.
        end
        for (int s = 1; s < MUL_LAT; s++) begin
            if (valid_q[s-1]) begin
                prod_q[s] <= prod_q[s-1];
            end
        end
    end

    assign prod_o       = prod_q[MUL_LAT-1];
    assign prod_valid_o = valid_q[MUL_LAT-1];

endmodule

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ai_unit_tb -f vlog.f
./obj_dir/Vai_unit_tb 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    echo "Simulation ended without a verdict, see sim.log"
    exit 1
fi

// File: tests/ai_unit_chk.sv
`timescale 1ns/1ns

module ai_unit_chk
    import ai_pkg::*;
#(
    parameter int N_REGS = 8,
    parameter int CNT_W  = 4
) (
    input logic              clk_i,
    input logic              rstn_i,
    input logic [CNT_W-1:0]  fill_x_i,
    input logic [CNT_W-1:0]  fill_w_i,
    input logic [CNT_W-1:0]  req_cnt_i,
    input logic [CNT_W-1:0]  res_cnt_i,
    input logic              flush_i,
    input logic              prod_valid_i,
    input logic [DATA_W-1:0] acc_i
);

    res_within_fill: assert property (@(posedge clk_i) disable iff (!rstn_i)
        res_cnt_i <= fill_x_i && res_cnt_i <= fill_w_i)
        else $error("Result count passed a fill count.");

    // Request count leads the result count by zero or one.
    one_outstanding: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_cnt_i >= res_cnt_i && (req_cnt_i - res_cnt_i) <= CNT_W'(1))
        else $error("More than one product outstanding.");

    // No stale product leaves the multiplier after a clear.
    acc_cleared: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> acc_i == '0 && !prod_valid_i)
        else $error("Accumulator or multiplier not cleared after a clear.");

    fill_bounded: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fill_x_i <= CNT_W'(N_REGS) && fill_w_i <= CNT_W'(N_REGS))
        else $error("Fill count above buffer depth.");

endmodule

bind dot_unit ai_unit_chk #(
    .N_REGS (N_REGS),
    .CNT_W  (CNT_W)
) i_chk (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .fill_x_i     (fill_q[0]),
    .fill_w_i     (fill_q[1]),
    .req_cnt_i    (req_cnt_q),
    .res_cnt_i    (res_cnt_q),
    .flush_i      (flush),
    .prod_valid_i (prod_valid),
    .acc_i        (acc_q)
);

// File: tests/ai_unit_tb.sv
`timescale 1ns/1ns

module ai_unit_tb
    import ai_pkg::*;
();

    localparam int N_REGS      = 8;  // Same as the top level default.
    localparam int RUN_TIMEOUT = 200;

    logic              clk;
    logic              rstn;
    logic [FUNC_W-1:0] func;
    logic [DATA_W-1:0] opnd1;
    logic [DATA_W-1:0] opnd2;
    logic [DATA_W-1:0] result;
    logic              ready;

    // Shadow buffers, index 0 for x and 1 for w.
    logic [DATA_W-1:0] shadow [2][N_REGS];
    int                cnt [2];
    int                seed;
    bit                passed;
    bit                fail_shown;

    ai_unit_top i_dut (
        .clk_i    (clk),
        .rstn_i   (rstn),
        .func_i   (func),
        .opnd1_i  (opnd1),
        .opnd2_i  (opnd2),
        .result_o (result),
        .ready_o  (ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure();
        fail_shown = 1'b1;
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    // One operation for one cycle, then back to NOP.
    task automatic issue_op(input logic [FUNC_W-1:0] f, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b);
        @(posedge clk);
        func  <= f;
        opnd1 <= a;
        opnd2 <= b;
        @(posedge clk);
        func  <= OP_NOP;
        opnd1 <= '0;
        opnd2 <= '0;
    endtask

    task automatic push_value(input int b, input logic [DATA_W-1:0] v);
        if (cnt[b] < N_REGS) begin  // Full buffer drops the value.
            shadow[b][cnt[b]] = v;
            cnt[b]++;
        end
    endtask

    task automatic load_rand(input int b, input bit two);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] c;
        ai_op_e            op;
        a = $random(seed);
        c = $random(seed);
        if (b == 0) begin
            op = two ? OP_LDX_TWO : OP_LDX_ONE;
        end else begin
            op = two ? OP_LDW_TWO : OP_LDW_ONE;
        end
        issue_op(op, a, c);
        push_value(b, a);
        if (two) push_value(b, c);
    endtask

    task automatic fill_singles(input int b, input int n);
        for (int i = 0; i < n; i++) load_rand(b, 1'b0);
    endtask

    task automatic clear_buf(input int b);
        issue_op((b == 0) ? OP_CLRX : OP_CLRW, '0, '0);
        cnt[b] = 0;
    endtask

    // Low DATA_W bits of each product, summed over the shorter buffer.
    function automatic logic [DATA_W-1:0] dot_ref();
        logic [DATA_W-1:0] sum;
        int                n;
        sum = '0;
        n = (cnt[0] < cnt[1]) ? cnt[0] : cnt[1];
        for (int i = 0; i < n; i++) begin
            sum = sum + shadow[0][i] * shadow[1][i];
        end
        return sum;
    endfunction

    task automatic run_and_check(input string name, output int waited);
        logic [DATA_W-1:0] expected;
        expected = dot_ref();
        waited = 0;
        @(posedge clk);
        func <= OP_RUN;
        @(negedge clk);
        while (!ready) begin
            waited++;
            if (waited > RUN_TIMEOUT) begin
                $display("Run %s timed out, ready stayed low for %0d cycles", name, waited);
                report_failure();
            end
            @(negedge clk);
        end
        check_value(name, expected, result);
        @(posedge clk);
        func <= OP_NOP;
    endtask

    initial begin
        int waited;
        int b;
        seed       = 92704;
        passed     = 1'b0;
        fail_shown = 1'b0;
        rstn       = 1'b0;
        func       = '0;
        opnd1      = '0;
        opnd2      = '0;
        cnt[0]     = 0;
        cnt[1]     = 0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_value("reset_result", '0, result);
        run_and_check("empty_run", waited);
        check_value("empty_run_wait", '0, DATA_W'(waited));  // Ready at once.

        fill_singles(0, 6);
        fill_singles(1, 3);
        run_and_check("single_x_longer", waited);
        clear_buf(0);
        clear_buf(1);
        fill_singles(0, 2);
        fill_singles(1, 7);
        run_and_check("single_w_longer", waited);

        clear_buf(0);
        clear_buf(1);
        load_rand(0, 1'b1);
        load_rand(1, 1'b1);
        for (int i = 0; i < 6; i++) begin
            b = {$random(seed)} % 2;
            load_rand(b, bit'({$random(seed)} % 2));
        end
        run_and_check("pair_mix", waited);

        clear_buf(0);
        clear_buf(1);
        for (int i = 0; i < 5; i++) load_rand(0, 1'b1);
        fill_singles(1, 7);
        load_rand(1, 1'b1);  // Second value falls off the end.
        run_and_check("overflow", waited);

        for (int k = 0; k < 2; k++) begin
            clear_buf(0);
            clear_buf(1);
            fill_singles(0, 6);
            fill_singles(1, 6);
            clear_buf(k);  // Products of the old values still in flight.
            fill_singles(k, 4);
            run_and_check((k == 0) ? "clear_x_in_flight" : "clear_w_in_flight", waited);
        end

        clear_buf(0);
        clear_buf(1);
        for (int i = 0; i < 6; i++) begin
            load_rand(i % 2, i >= 3);
            issue_op(FUNC_W'(8 + {$random(seed)} % 8), $random(seed), $random(seed));
        end
        issue_op(OP_NOP, $random(seed), $random(seed));
        run_and_check("undefined_codes", waited);

        passed = 1'b1;
        $display("=== PASS ===");
        $finish;
    end

    // Catches runs stopped by an assertion.
    final begin
        if (!passed && !fail_shown) begin
            $display("=== FAIL ===");
        end
    end

endmodule

// File: vlog.f
rtl/ai_pkg.sv
rtl/ai_op_decode.sv
rtl/mul_pipe.sv
rtl/dot_unit.sv
rtl/ai_unit_top.sv
tests/ai_unit_chk.sv
tests/ai_unit_tb.sv
